//--- filelist.f
+incdir+logic
logic/fdiv_pkg.sv
logic/fp_classify.sv
logic/fp_mant_div.sv
logic/fp_div.sv
logic/fp_div_round.sv
logic/fp_div_top.sv
tb/fp_div_sva.sv
tb/fp_div_tb.sv

//--- logic/fdiv_macros.svh
// Binary32 format constants for the divide unit, pulled in with `include where a width is needed
`ifndef FDIV_MACROS_SVH
`define FDIV_MACROS_SVH
`default_nettype none

// Word layout
`define FDIV_FLEN 32
`define FDIV_EXPO_W 8
`define FDIV_FRAC_W 23

// Exponent bias of the format
`define FDIV_BIAS 127

// Guard, round and sticky bits handed to the rounding stage
`define FDIV_GRS_W 3

// Positive quiet NaN with only the top fraction bit set
`define FDIV_CANON_NAN 32'h7fc0_0000

`default_nettype wire
`endif

//--- logic/fdiv_pkg.sv
// Types shared by the divide unit stages, referenced with fdiv_pkg:: scoped names
`include "fdiv_macros.svh"
`default_nettype none

package fdiv_pkg;

    // RISC-V rounding mode encodings
    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } round_mode_e;

    // Mantissa core sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } div_state_e;

    // Two extra bits hold the signed exponent range of a quotient
    typedef logic [`FDIV_EXPO_W+1:0] expo_ext_t;
    typedef logic [4:0] shift_amt_t;

    typedef struct packed {
        logic sign;
        logic [`FDIV_EXPO_W-1:0] expo;
        logic [`FDIV_FRAC_W-1:0] frac;
    } fp_t;

    // Operand class bits
    typedef struct packed {
        logic zero;
        logic inf;
        logic snan;
        logic qnan;
        logic subnormal;
    } special_t;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        fp_t a;
        fp_t b;
        round_mode_e rm;
    } fdiv_req_t;

    // Classifier output, fractions already prenormalized
    typedef struct packed {
        fp_t a;
        fp_t b;
        special_t a_special;
        special_t b_special;
        logic a_hidden;
        logic b_hidden;
        shift_amt_t a_shift;
        shift_amt_t b_shift;
        round_mode_e rm;
    } fdiv_args_t;

    // Divider record for the rounding stage
    typedef struct packed {
        logic sign;
        expo_ext_t expo;
        logic hidden;
        logic [`FDIV_FRAC_W-1:0] frac;
        logic [`FDIV_GRS_W-1:0] grs;
        logic expo_overflow;
        logic right_shift;
        shift_amt_t right_shift_amt;
        logic special;
        logic nv;
        logic dz;
        round_mode_e rm;
    } fdiv_inter_t;

    typedef struct packed {
        fp_t result;
        fflags_t fflags;
    } fdiv_resp_t;

endpackage

`default_nettype wire

//--- logic/fp_classify.sv
// Producer stage of the divide unit: classifies and prenormalizes both operands into one register
`include "fdiv_macros.svh"
`default_nettype none
`timescale 1ns/100ps

module fp_classify (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  fdiv_pkg::fdiv_req_t req,
    output logic                args_valid,
    input  logic                args_ready,
    output fdiv_pkg::fdiv_args_t args
);

    // Class bits from the exponent and fraction fields
    function automatic fdiv_pkg::special_t classify(input fdiv_pkg::fp_t x);
        fdiv_pkg::special_t c;
        logic expo_zero;
        logic expo_ones;
        logic frac_zero;
        expo_zero = (x.expo == '0);
        expo_ones = (x.expo == '1);
        frac_zero = (x.frac == '0);
        c.zero = expo_zero & frac_zero;
        c.subnormal = expo_zero & ~frac_zero;
        c.inf = expo_ones & frac_zero;
        // Top fraction bit splits quiet from signaling
        c.qnan = expo_ones & ~frac_zero & x.frac[`FDIV_FRAC_W-1];
        c.snan = expo_ones & ~frac_zero & ~x.frac[`FDIV_FRAC_W-1];
        return c;
    endfunction

    // Left shift that moves the leading one of a subnormal into the hidden position
    function automatic fdiv_pkg::shift_amt_t prenorm_shift(input fdiv_pkg::fp_t x);
        fdiv_pkg::shift_amt_t lz;
        logic found;
        lz = '0;
        found = 1'b0;
        for (int i = `FDIV_FRAC_W - 1; i >= 0; i--) begin
            if (!found && !x.frac[i])
                lz = lz + 5'd1;
            else
                found = 1'b1;
        end
        if (x.expo == '0 && x.frac != '0)
            return lz + 5'd1;
        return '0;
    endfunction

    fdiv_pkg::fdiv_args_t args_next;
    logic live_r;

    always_comb begin
        args_next.a = req.a;
        args_next.b = req.b;
        args_next.a_special = classify(req.a);
        args_next.b_special = classify(req.b);
        args_next.a_hidden = |req.a.expo;
        args_next.b_hidden = |req.b.expo;
        args_next.a_shift = prenorm_shift(req.a);
        args_next.b_shift = prenorm_shift(req.b);
        // Shift applies to subnormals only, normal operands see zero
        args_next.a.frac = req.a.frac << args_next.a_shift;
        args_next.b.frac = req.b.frac << args_next.b_shift;
        args_next.rm = req.rm;
    end

    // Entry free, or leaving this cycle
    assign req_ready = live_r & (~args_valid | args_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            live_r <= 1'b0;
            args_valid <= 1'b0;
        end else begin
            live_r <= 1'b1;
            if (req_valid && req_ready)
                args_valid <= 1'b1;
            else if (args_ready)
                args_valid <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (req_valid && req_ready)
            args <= args_next;
    end

endmodule

`default_nettype wire

//--- logic/fp_div.sv
// Divider unit: early exit for special operands, exponent subtract and the iterative mantissa core
`include "fdiv_macros.svh"
`default_nettype none
`timescale 1ns/100ps

module fp_div (
    input  logic                   clk,
    input  logic                   rst,
    input  fdiv_pkg::fdiv_args_t   args,
    input  logic                   args_valid,
    output logic                   args_ready,
    output fdiv_pkg::fdiv_inter_t  inter,
    output logic                   inter_valid,
    input  logic                   inter_ack
);

    logic accept;
    logic busy;
    logic early_r;
    logic fin_r;

    // Issue ready, free or handing off this cycle
    assign args_ready = ~busy | inter_ack;
    assign accept = args_valid & args_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Special operands
    logic nv, dz, qnan, inf, zero, special;
    logic a_num;
    logic sign_r, nv_r, dz_r, qnan_r, zero_r;
    fdiv_pkg::round_mode_e rm_r;
    fdiv_pkg::fp_t spec;

    // Finite and nonzero dividend, normal or subnormal
    assign a_num = ~(args.a_special.zero | args.a_special.inf |
                     args.a_special.snan | args.a_special.qnan);
    assign nv = (args.a_special.zero & args.b_special.zero) |
                (args.a_special.inf & args.b_special.inf) |
                args.a_special.snan | args.b_special.snan;
    assign dz = a_num & args.b_special.zero;
    assign qnan = nv | args.a_special.qnan | args.b_special.qnan;
    assign inf = ~qnan & (dz | args.a_special.inf);
    assign zero = ~qnan & (args.a_special.zero | args.b_special.inf);
    assign special = qnan | inf | zero;

    always_comb begin
        spec.sign = sign_r;
        spec.expo = '1;
        spec.frac = '0;
        if (qnan_r)
            spec = `FDIV_CANON_NAN;
        else if (zero_r)
            spec.expo = '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Exponent difference
    // Subnormals count as exponent one minus their prenormalize shift
    fdiv_pkg::expo_ext_t eff_a, eff_b, expo_diff, expo_r, e_norm, rs_full;
    logic [`FDIV_FRAC_W+2:0] quotient;
    logic rem_nz;
    logic core_done;

    assign eff_a = {2'b0, args.a.expo} + {9'b0, ~args.a_hidden} - {5'b0, args.a_shift};
    assign eff_b = {2'b0, args.b.expo} + {9'b0, ~args.b_hidden} - {5'b0, args.b_shift};
    assign expo_diff = eff_a - eff_b + fdiv_pkg::expo_ext_t'(`FDIV_BIAS);

    // Quotient below one costs an exponent step
    assign e_norm = expo_r - {9'b0, ~quotient[`FDIV_FRAC_W+2]};
    assign rs_full = fdiv_pkg::expo_ext_t'(1) - e_norm;

    ////////////////////////////////////////////////////////////////////////////
    // Request hold
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            early_r <= 1'b0;
            fin_r <= 1'b0;
        end else begin
            if (inter_ack) begin
                busy <= 1'b0;
                early_r <= 1'b0;
                fin_r <= 1'b0;
            end else if (core_done) begin
                fin_r <= 1'b1;
            end
            if (accept) begin
                busy <= 1'b1;
                early_r <= special;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sign_r <= args.a.sign ^ args.b.sign;
            nv_r <= nv;
            dz_r <= dz;
            qnan_r <= qnan;
            zero_r <= zero;
            expo_r <= expo_diff;
            rm_r <= args.rm;
        end
    end

    // Core only runs for ordinary operands
    fp_mant_div i_core (
        .clk       (clk),
        .rst       (rst),
        .start     (accept & ~special),
        .dividend  ({1'b1, args.a.frac, 2'b00}),
        .divisor   ({1'b1, args.b.frac, 2'b00}),
        .quotient  (quotient),
        .remainder (rem_nz),
        .done      (core_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Record for rounding
    assign inter_valid = early_r | fin_r | core_done;

    always_comb begin
        inter.sign = early_r ? spec.sign : sign_r;
        inter.expo = early_r ? {2'b00, spec.expo} : e_norm;
        inter.hidden = quotient[`FDIV_FRAC_W+2];
        inter.frac = early_r ? spec.frac : quotient[`FDIV_FRAC_W+1:2];
        inter.grs = early_r ? '0 : {quotient[1:0], rem_nz};
        inter.expo_overflow = ~early_r & ~e_norm[9] & (e_norm >= 10'd255);
        // Zero or negative biased exponent gives a subnormal
        inter.right_shift = ~early_r & (e_norm[9] | (e_norm == '0));
        // Past 26 everything lands in sticky
        inter.right_shift_amt = (rs_full > 10'd26) ? 5'd26 : rs_full[4:0];
        inter.special = early_r;
        inter.nv = nv_r;
        inter.dz = dz_r;
        inter.rm = rm_r;
    end

endmodule

`default_nettype wire

//--- logic/fp_div_round.sv
// Rounding stage that normalizes, rounds, raises flags and holds the response for the top level
`include "fdiv_macros.svh"
`default_nettype none
`timescale 1ns/100ps

module fp_div_round (
    input  logic                  clk,
    input  logic                  rst,
    input  fdiv_pkg::fdiv_inter_t inter,
    input  logic                  inter_valid,
    output logic                  inter_ack,
    output fdiv_pkg::fdiv_resp_t  resp,
    output logic                  resp_valid,
    input  logic                  resp_ready
);

    logic [`FDIV_FRAC_W:0] mant, mant_d;
    logic guard, guard_d;
    logic sticky, sticky_d;
    logic [51:0] wide;
    logic inc, to_inf, overflow, inexact;
    logic [`FDIV_FRAC_W+1:0] sum;
    fdiv_pkg::expo_ext_t expo_rnd;
    fdiv_pkg::fdiv_resp_t resp_next;

    // Accept when the output register is empty or draining
    assign inter_ack = inter_valid & (~resp_valid | resp_ready);

    ////////////////////////////////////////////////////////////////////////////
    // Normalize and denormalize
    always_comb begin
        if (inter.hidden) begin
            mant = {1'b1, inter.frac};
            guard = inter.grs[2];
            sticky = inter.grs[1] | inter.grs[0];
        end else begin
            // Quotient below one needs one bit pulled up
            mant = {inter.frac, inter.grs[2]};
            guard = inter.grs[1];
            sticky = inter.grs[0];
        end
    end

    assign wide = {mant, guard, 27'b0} >> inter.right_shift_amt;
    assign mant_d = inter.right_shift ? wide[51:28] : mant;
    assign guard_d = inter.right_shift ? wide[27] : guard;
    // Bits pushed past guard fold into sticky
    assign sticky_d = inter.right_shift ? (|wide[26:0] | sticky) : sticky;

    ////////////////////////////////////////////////////////////////////////////
    // Round by mode
    always_comb begin
        case (inter.rm)
            fdiv_pkg::RNE: inc = guard_d & (sticky_d | mant_d[0]);
            fdiv_pkg::RDN: inc = inter.sign & (guard_d | sticky_d);
            fdiv_pkg::RUP: inc = ~inter.sign & (guard_d | sticky_d);
            fdiv_pkg::RMM: inc = guard_d;
            default: inc = 1'b0;
        endcase
        case (inter.rm)
            fdiv_pkg::RNE, fdiv_pkg::RMM: to_inf = 1'b1;
            fdiv_pkg::RDN: to_inf = inter.sign;
            fdiv_pkg::RUP: to_inf = ~inter.sign;
            default: to_inf = 1'b0;
        endcase
    end

    assign sum = {1'b0, mant_d} + {{(`FDIV_FRAC_W+1){1'b0}}, inc};
    // Carry out of the mantissa bumps the exponent
    assign expo_rnd = inter.expo + {9'b0, sum[`FDIV_FRAC_W+1]};
    assign overflow = ~inter.special & ~inter.right_shift &
                      (inter.expo_overflow | (expo_rnd == 10'd255));
    assign inexact = guard_d | sticky_d | overflow;

    always_comb begin
        resp_next.result.sign = inter.sign;
        resp_next.fflags = '0;
        resp_next.fflags.nv = inter.nv;
        resp_next.fflags.dz = inter.dz;
        if (inter.special) begin
            // Early exit word passes straight through
            resp_next.result.expo = inter.expo[`FDIV_EXPO_W-1:0];
            resp_next.result.frac = inter.frac;
        end else if (overflow) begin
            resp_next.result.expo = to_inf ? 8'hff : 8'hfe;
            resp_next.result.frac = to_inf ? '0 : '1;
            resp_next.fflags.of = 1'b1;
            resp_next.fflags.nx = 1'b1;
        end else begin
            // Subnormal rounding up to the hidden bit turns normal
            resp_next.result.expo = inter.right_shift ? {7'b0, sum[`FDIV_FRAC_W]}
                                                      : expo_rnd[`FDIV_EXPO_W-1:0];
            // A mantissa carry leaves the fraction bits all zero
            resp_next.result.frac = sum[`FDIV_FRAC_W-1:0];
            resp_next.fflags.nx = inexact;
            resp_next.fflags.uf = inter.right_shift & inexact;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (rst)
            resp_valid <= 1'b0;
        else if (inter_ack)
            resp_valid <= 1'b1;
        else if (resp_ready)
            resp_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (inter_ack)
            resp <= resp_next;
    end

endmodule

`default_nettype wire

//--- logic/fp_div_top.sv
// Top of the binary32 divide unit: classifier, divider and rounding stage in a chain
`default_nettype none
`timescale 1ns/100ps

module fp_div_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  fdiv_pkg::fdiv_req_t  req,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output fdiv_pkg::fdiv_resp_t resp
);

    // Classifier to divider
    fdiv_pkg::fdiv_args_t args;
    logic args_valid;
    logic args_ready;

    // Divider to rounding
    fdiv_pkg::fdiv_inter_t inter;
    logic inter_valid;
    logic inter_ack;

    fp_classify i_classify (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .args_valid (args_valid),
        .args_ready (args_ready),
        .args       (args)
    );

    fp_div i_div (
        .clk         (clk),
        .rst         (rst),
        .args        (args),
        .args_valid  (args_valid),
        .args_ready  (args_ready),
        .inter       (inter),
        .inter_valid (inter_valid),
        .inter_ack   (inter_ack)
    );

    fp_div_round i_round (
        .clk         (clk),
        .rst         (rst),
        .inter       (inter),
        .inter_valid (inter_valid),
        .inter_ack   (inter_ack),
        .resp        (resp),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready)
    );

endmodule

`default_nettype wire

//--- logic/fp_mant_div.sv
// Restoring radix-2 mantissa divider, one quotient bit per cycle, used inside the divider unit
`include "fdiv_macros.svh"
`default_nettype none
`timescale 1ns/100ps

module fp_mant_div (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [`FDIV_FRAC_W+2:0]   dividend,
    input  logic [`FDIV_FRAC_W+2:0]   divisor,
    output logic [`FDIV_FRAC_W+2:0]   quotient,
    output logic                      remainder,
    output logic                      done
);

    fdiv_pkg::div_state_e state;
    logic [4:0] count;

    // Partial remainder stays below twice the divisor
    logic [`FDIV_FRAC_W+3:0] rem;
    logic [`FDIV_FRAC_W+2:0] divisor_r;
    logic [`FDIV_FRAC_W+4:0] trial;

    assign trial = {1'b0, rem} - {2'b0, divisor_r};

    ////////////////////////////////////////////////////////////////////////////
    // Control
    // 26 quotient bits in RUN, then one DONE cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fdiv_pkg::IDLE;
            count <= '0;
        end else if (start) begin
            state <= fdiv_pkg::RUN;
            count <= '0;
        end else begin
            case (state)
                fdiv_pkg::RUN: begin
                    count <= count + 5'd1;
                    if (count == 5'(`FDIV_FRAC_W + 2))
                        state <= fdiv_pkg::DONE;
                end
                fdiv_pkg::DONE: state <= fdiv_pkg::IDLE;
                default: state <= fdiv_pkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift-subtract datapath
    always_ff @(posedge clk) begin
        if (start) begin
            rem <= {1'b0, dividend};
            divisor_r <= divisor;
            quotient <= '0;
        end else if (state == fdiv_pkg::RUN) begin
            // No borrow means the divisor fits, quotient bit is one
            quotient <= {quotient[`FDIV_FRAC_W+1:0], ~trial[`FDIV_FRAC_W+4]};
            if (trial[`FDIV_FRAC_W+4])
                rem <= rem << 1;
            else
                rem <= trial[`FDIV_FRAC_W+3:0] << 1;
        end
    end

    // Any leftover remainder becomes sticky
    assign remainder = |rem;
    assign done = (state == fdiv_pkg::DONE);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the divide unit testbench with Verilator and run it
# The exit status is nonzero when the build fails or the simulation ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fp_div_tb -f filelist.f -o fp_div_sim \
    && ./obj_dir/fp_div_sim \
    || { echo "fp_div simulation did not complete cleanly"; exit 1; }

exit 0

//--- tb/fp_div_sva.sv
// Handshake and reset assertions for the divide unit top level, attached to it by bind
`default_nettype none
`timescale 1ns/100ps

module fp_div_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 req_valid,
    input logic                 req_ready,
    input fdiv_pkg::fdiv_req_t  req,
    input logic                 resp_valid,
    input logic                 resp_ready,
    input fdiv_pkg::fdiv_resp_t resp
);

    // Nothing offered or accepted in the cycle after a reset edge
    reset_idle: assert property (@(posedge clk) rst |=> (!resp_valid && !req_ready))
        else $error("resp_valid or req_ready high in the cycle after reset");

    // Stalled response keeps its valid and payload
    resp_hold: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
        else $error("response dropped or changed while resp_ready was low");

    // Stalled request keeps its valid and payload
    req_hold: assert property (@(posedge clk) disable iff (rst)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else $error("request dropped or changed while req_ready was low");

endmodule

bind fp_div_top fp_div_sva i_sva (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
);

`default_nettype wire

//--- tb/fp_div_tb.sv
// Testbench for the binary32 divide unit that runs a vector table through the top level in order
`default_nettype none
`timescale 1ns/100ps

module fp_div_tb;

    localparam int MAX_VECS = 32;
    // Cycles allowed for any single handshake wait
    localparam int WAIT_LIMIT = 400;

    // Flag weights in nv dz of uf nx order
    localparam logic [4:0] F_NV = 5'h10;
    localparam logic [4:0] F_DZ = 5'h08;
    localparam logic [4:0] F_OF = 5'h04;
    localparam logic [4:0] F_UF = 5'h02;
    localparam logic [4:0] F_NX = 5'h01;

    // One table row with operands and rounding mode in and expected word and flags out
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        fdiv_pkg::round_mode_e rm;
        logic [31:0] res;
        logic [4:0] flags;
    } vec_t;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_ready;
    fdiv_pkg::fdiv_req_t req;
    logic resp_valid;
    logic resp_ready;
    fdiv_pkg::fdiv_resp_t resp;

    vec_t vecs [MAX_VECS];
    int nvecs;

    fp_div_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Vector table
    task automatic put_row(input logic [31:0] a, input logic [31:0] b,
                           input fdiv_pkg::round_mode_e rm, input logic [31:0] res,
                           input logic [4:0] flags);
        vecs[nvecs] = '{a, b, rm, res, flags};
        nvecs++;
    endtask

    task automatic load_vectors();
        nvecs = 0;
        // Exact normal quotients
        put_row(32'h40c0_0000, 32'h4000_0000, fdiv_pkg::RNE, 32'h4040_0000, 5'h00);
        put_row(32'h3f80_0000, 32'h4080_0000, fdiv_pkg::RNE, 32'h3e80_0000, 5'h00);
        put_row(32'hc110_0000, 32'h4040_0000, fdiv_pkg::RNE, 32'hc040_0000, 5'h00);
        // One third leaves guard and sticky set
        put_row(32'h3f80_0000, 32'h4040_0000, fdiv_pkg::RNE, 32'h3eaa_aaab, F_NX);
        put_row(32'h3f80_0000, 32'h4040_0000, fdiv_pkg::RTZ, 32'h3eaa_aaaa, F_NX);
        put_row(32'h3f80_0000, 32'h4040_0000, fdiv_pkg::RDN, 32'h3eaa_aaaa, F_NX);
        put_row(32'h3f80_0000, 32'h4040_0000, fdiv_pkg::RUP, 32'h3eaa_aaab, F_NX);
        put_row(32'h3f80_0000, 32'h4040_0000, fdiv_pkg::RMM, 32'h3eaa_aaab, F_NX);
        // Directed modes swap for a negative third
        put_row(32'hbf80_0000, 32'h4040_0000, fdiv_pkg::RDN, 32'hbeaa_aaab, F_NX);
        put_row(32'hbf80_0000, 32'h4040_0000, fdiv_pkg::RUP, 32'hbeaa_aaaa, F_NX);
        // Invalid operations give the canonical NaN
        put_row(32'h0000_0000, 32'h0000_0000, fdiv_pkg::RNE, 32'h7fc0_0000, F_NV);
        put_row(32'h7f80_0000, 32'h7f80_0000, fdiv_pkg::RNE, 32'h7fc0_0000, F_NV);
        put_row(32'h7f80_0001, 32'h3f80_0000, fdiv_pkg::RNE, 32'h7fc0_0000, F_NV);
        // Quiet NaN propagates without nv
        put_row(32'h7fc0_0001, 32'h3f80_0000, fdiv_pkg::RNE, 32'h7fc0_0000, 5'h00);
        // Finite over negative zero
        put_row(32'h40a0_0000, 32'h8000_0000, fdiv_pkg::RNE, 32'hff80_0000, F_DZ);
        put_row(32'h8000_0000, 32'h40e0_0000, fdiv_pkg::RNE, 32'h8000_0000, 5'h00);
        put_row(32'h4040_0000, 32'h7f80_0000, fdiv_pkg::RNE, 32'h0000_0000, 5'h00);
        // Largest finite over one half
        put_row(32'h7f7f_ffff, 32'h3f00_0000, fdiv_pkg::RNE, 32'h7f80_0000, F_OF | F_NX);
        put_row(32'h7f7f_ffff, 32'h3f00_0000, fdiv_pkg::RTZ, 32'h7f7f_ffff, F_OF | F_NX);
        // Smallest normal over four lands exactly on a subnormal
        put_row(32'h0080_0000, 32'h4080_0000, fdiv_pkg::RNE, 32'h0020_0000, 5'h00);
        // Three ulps above it loses two bits and rounds up
        put_row(32'h0080_0003, 32'h4080_0000, fdiv_pkg::RNE, 32'h0020_0001, F_UF | F_NX);
        // Smallest subnormal over smallest normal is two to the minus 23
        put_row(32'h0000_0001, 32'h0080_0000, fdiv_pkg::RNE, 32'h3400_0000, 5'h00);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and response
    // Requests go back to back and each is held until req_ready is seen at mid cycle
    task automatic send_requests();
        int waited;
        for (int i = 0; i < nvecs; i++) begin
            req.a = fdiv_pkg::fp_t'(vecs[i].a);
            req.b = fdiv_pkg::fp_t'(vecs[i].b);
            req.rm = vecs[i].rm;
            req_valid = 1'b1;
            waited = 0;
            @(negedge clk);
            while (!req_ready) begin
                waited++;
                if (waited > WAIT_LIMIT)
                    abort_run($sformatf("Timed out waiting for req_ready on row %0d", i));
                @(negedge clk);
            end
            // Transfer on this edge
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    // Random stall before each response and then a compare in table order
    task automatic collect_responses();
        int waited;
        int stall;
        for (int j = 0; j < nvecs; j++) begin
            stall = int'($urandom % 4);
            if (stall > 0) begin
                resp_ready = 1'b0;
                repeat (stall) begin
                    @(posedge clk);
                    #1;
                end
                resp_ready = 1'b1;
            end
            waited = 0;
            @(negedge clk);
            while (!resp_valid) begin
                waited++;
                if (waited > WAIT_LIMIT)
                    abort_run($sformatf("Timed out waiting for resp_valid on row %0d", j));
                @(negedge clk);
            end
            check_value($sformatf("resp.result row %0d", j), 32'(resp.result), vecs[j].res);
            check_value($sformatf("resp.fflags row %0d", j), 32'(resp.fflags),
                        32'(vecs[j].flags));
            @(posedge clk);
            #1;
        end
    endtask

    // No extra response may follow the last one
    task automatic check_idle();
        repeat (40) begin
            @(negedge clk);
            check_value("resp_valid after last response", 32'(resp_valid), 32'h0);
        end
    endtask

    initial begin
        void'($urandom(57107));
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b1;
        load_vectors();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            send_requests();
            collect_responses();
        join
        check_idle();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
